// ==== include/riscv_dm_settings.svh ====
`ifndef RISCV_DM_SETTINGS_SVH
`define RISCV_DM_SETTINGS_SVH

// Storage size in bytes, eight bytes per row.
`define RISCV_DM_DEPTH_BYTES 256

`define RISCV_DM_XLEN 64    // Core data width.

`define RISCV_DM_APB_W 32   // APB data width.

`define RISCV_DM_ADDR_W 64  // Core and APB byte address width.

`endif

// ==== src/riscv_dm_pkg.sv ====
`default_nettype none

`include "riscv_dm_settings.svh"

package riscv_dm_pkg;

  // Access size, same code as the lb/lh/lw/ld funct3 low bits.
  typedef enum logic [1:0] {
    SZ_BYTE  = 2'd0,
    SZ_HALF  = 2'd1,
    SZ_WORD  = 2'd2,
    SZ_DWORD = 2'd3
  } dm_size_e;

  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,  // No APB transfer in flight.
    ST_ACCESS  = 2'd1,  // Access phase, waiting for a free slot.
    ST_WAIT_RD = 2'd2   // Bank read issued, data next cycle.
  } dm_state_e;

  typedef logic [`RISCV_DM_ADDR_W-1:0] dm_addr_t;  // Byte address.
  typedef logic [`RISCV_DM_XLEN-1:0]   dm_data_t;  // Double word.

  // One row holds XLEN/8 bytes.
  typedef logic [$clog2(`RISCV_DM_DEPTH_BYTES/(`RISCV_DM_XLEN/8))-1:0] dm_row_t;

  typedef logic [`RISCV_DM_XLEN/8-1:0]          dm_byte_en_t;  // Per-lane write enable.
  typedef logic [$clog2(`RISCV_DM_XLEN/8)-1:0]  dm_offset_t;   // Byte inside a row.

endpackage

`default_nettype wire

// ==== src/riscv_dm_if.sv ====
`default_nettype none

// One access per cycle from the controller to the datapath.
interface riscv_dm_req_if;
  logic                    en;
  logic                    we;
  riscv_dm_pkg::dm_addr_t  addr;
  riscv_dm_pkg::dm_size_e  size;
  logic                    is_unsigned;  // Zero-extend on load.
  riscv_dm_pkg::dm_data_t  wdata;

  modport ctrl (output en, we, addr, size, is_unsigned, wdata);
  modport dp   (input en, we, addr, size, wdata);
  modport ext  (input en, we, addr, size, is_unsigned);
endinterface

interface riscv_dm_bank_if;
  logic                         en;
  logic                         we;
  riscv_dm_pkg::dm_row_t        row;
  riscv_dm_pkg::dm_byte_en_t    byte_en;
  riscv_dm_pkg::dm_data_t       wdata;    // Already lane aligned.
  riscv_dm_pkg::dm_data_t       rdata;    // Whole row, one cycle after en.

  modport drv (output en, we, row, byte_en, wdata);
  modport mem (input en, we, row, byte_en, wdata, output rdata);
endinterface

`default_nettype wire

// ==== src/riscv_dm_ctrl.sv ====
`default_nettype none

`include "riscv_dm_settings.svh"

module riscv_dm_ctrl (
  input  wire logic                        i_riscv_dm_rst,    // Clock.
  input  wire logic                        i_riscv_dm_clk_n,  // Async reset, active low.
  input  wire logic                        i_core_req,
  input  wire logic                        i_core_we,
  input  wire riscv_dm_pkg::dm_size_e      i_core_size,
  input  wire logic                        i_core_unsigned,
  input  wire riscv_dm_pkg::dm_addr_t      i_core_addr,
  input  wire riscv_dm_pkg::dm_data_t      i_core_wdata,
  output logic                             o_core_rvalid,
  output logic                             o_core_fault,
  output riscv_dm_pkg::dm_data_t           o_core_rdata,
  input  wire logic                        i_apb_psel,
  input  wire logic                        i_apb_penable,
  input  wire logic                        i_apb_pwrite,
  input  wire riscv_dm_pkg::dm_addr_t      i_apb_paddr,
  input  wire logic [`RISCV_DM_APB_W-1:0]  i_apb_pwdata,
  output logic                             o_apb_pready,
  output logic [`RISCV_DM_APB_W-1:0]       o_apb_prdata,
  output logic                             o_apb_pslverr,
  input  wire riscv_dm_pkg::dm_data_t      i_load_data,
  riscv_dm_req_if.ctrl                     req
);

  localparam int OFF_W = $bits(riscv_dm_pkg::dm_offset_t);

  riscv_dm_pkg::dm_state_e   state_q;
  riscv_dm_pkg::dm_state_e   state_d;
  riscv_dm_pkg::dm_offset_t  core_off;
  logic                      core_misalign;
  logic                      apb_access;  // Access phase with no pending read.
  logic                      apb_bad;     // Out of range or not word aligned.
  logic                      rvalid_q;
  logic                      fault_q;
  logic                      core_rd_q;   // Pending read belongs to the core.

  always_comb
  begin
    core_off = i_core_addr[OFF_W-1:0];
    case (i_core_size)
      riscv_dm_pkg::SZ_BYTE: core_misalign = 1'b0;
      riscv_dm_pkg::SZ_HALF: core_misalign = core_off[0];
      riscv_dm_pkg::SZ_WORD: core_misalign = |core_off[1:0];
      default:               core_misalign = |core_off;
    endcase
  end

  assign apb_access = (state_q == riscv_dm_pkg::ST_ACCESS) && i_apb_psel && i_apb_penable;
  assign apb_bad    = (i_apb_paddr >= riscv_dm_pkg::dm_addr_t'(`RISCV_DM_DEPTH_BYTES)) ||
                      (i_apb_paddr[1:0] != 2'b00);

  // Core wins the slot, APB only goes out when the core is silent.
  always_comb
  begin
    if (i_core_req)
    begin
      req.en          = !core_misalign;  // Misaligned never reaches memory.
      req.we          = i_core_we;
      req.addr        = i_core_addr;
      req.size        = i_core_size;
      req.is_unsigned = i_core_unsigned;
      req.wdata       = i_core_wdata;
    end
    else
    begin
      req.en          = apb_access && !apb_bad;
      req.we          = i_apb_pwrite;
      req.addr        = i_apb_paddr;
      req.size        = riscv_dm_pkg::SZ_WORD;
      req.is_unsigned = 1'b1;
      req.wdata       = riscv_dm_pkg::dm_data_t'(i_apb_pwdata);
    end
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      riscv_dm_pkg::ST_IDLE:
      begin
        if (i_apb_psel && !i_apb_penable)
          state_d = riscv_dm_pkg::ST_ACCESS;  // Setup phase seen.
      end
      riscv_dm_pkg::ST_ACCESS:
      begin
        if (apb_access && !i_core_req)
          state_d = (!apb_bad && !i_apb_pwrite) ? riscv_dm_pkg::ST_WAIT_RD
                                                : riscv_dm_pkg::ST_IDLE;
      end
      default: state_d = riscv_dm_pkg::ST_IDLE;
    endcase
  end

  assign o_apb_pready  = (apb_access && !i_core_req && (apb_bad || i_apb_pwrite)) ||
                         (state_q == riscv_dm_pkg::ST_WAIT_RD);
  assign o_apb_pslverr = apb_access && !i_core_req && apb_bad;
  assign o_apb_prdata  = (state_q == riscv_dm_pkg::ST_WAIT_RD) ?
                         i_load_data[`RISCV_DM_APB_W-1:0] : '0;

  always_ff @(posedge i_riscv_dm_rst or negedge i_riscv_dm_clk_n)
  begin
    if (!i_riscv_dm_clk_n)
    begin
      state_q   <= riscv_dm_pkg::ST_IDLE;
      rvalid_q  <= 1'b0;
      fault_q   <= 1'b0;
      core_rd_q <= 1'b0;
    end
    else
    begin
      state_q   <= state_d;
      rvalid_q  <= i_core_req && (!i_core_we || core_misalign);
      fault_q   <= i_core_req && core_misalign;
      core_rd_q <= i_core_req && !i_core_we && !core_misalign;
    end
  end

  assign o_core_rvalid = rvalid_q;
  assign o_core_fault  = fault_q;
  assign o_core_rdata  = core_rd_q ? i_load_data : '0;  // Zero on fault.

  // A good APB read and a core load must never share the load extender.
  a_no_shared_read: assert property (@(posedge i_riscv_dm_rst) disable iff (!i_riscv_dm_clk_n)
    !(o_core_rvalid && o_apb_pready && !i_apb_pwrite && !o_apb_pslverr))
    else $error("core and APB read data returned in the same cycle");

  a_paddr_stable: assert property (@(posedge i_riscv_dm_rst) disable iff (!i_riscv_dm_clk_n)
    (apb_access && !o_apb_pready) |=> $stable(i_apb_paddr))
    else $error("PADDR changed while the transfer was waiting");

endmodule

`default_nettype wire

// ==== src/riscv_dm_store_align.sv ====
`default_nettype none

module riscv_dm_store_align (
  riscv_dm_req_if.dp    req,
  riscv_dm_bank_if.drv  bank
);

  localparam int LANES = $bits(riscv_dm_pkg::dm_byte_en_t);
  localparam int OFF_W = $bits(riscv_dm_pkg::dm_offset_t);
  localparam int ROW_W = $bits(riscv_dm_pkg::dm_row_t);

  riscv_dm_pkg::dm_offset_t   offset;
  riscv_dm_pkg::dm_byte_en_t  base_mask;  // Enables for offset zero.
  logic [2*LANES-1:0]         mask_wide;  // Upper half catches lane overflow.

  assign offset = req.addr[OFF_W-1:0];

  always_comb
  begin
    case (req.size)
      riscv_dm_pkg::SZ_BYTE: base_mask = riscv_dm_pkg::dm_byte_en_t'(8'h01);
      riscv_dm_pkg::SZ_HALF: base_mask = riscv_dm_pkg::dm_byte_en_t'(8'h03);
      riscv_dm_pkg::SZ_WORD: base_mask = riscv_dm_pkg::dm_byte_en_t'(8'h0f);
      default:               base_mask = '1;
    endcase
    mask_wide = {{LANES{1'b0}}, base_mask} << offset;
  end

  // Little endian, byte k of the value lands in lane offset+k.
  assign bank.en      = req.en;
  assign bank.we      = req.we;
  assign bank.row     = req.addr[OFF_W +: ROW_W];
  assign bank.byte_en = mask_wide[LANES-1:0];
  assign bank.wdata   = req.wdata << {offset, 3'b000};

  // Lanes past the row would mean a misaligned access slipped past the controller.
  always_comb
  begin
    if (req.en && req.we)
    begin
      a_lanes_in_row: assert final (mask_wide[2*LANES-1:LANES] == '0)
        else $error("store byte enables run past the last lane");
    end
  end

endmodule

`default_nettype wire

// ==== src/riscv_dm_bank.sv ====
`default_nettype none

`include "riscv_dm_settings.svh"

module riscv_dm_bank (
  input  wire logic     i_riscv_dm_rst,    // Clock.
  input  wire logic     i_riscv_dm_clk_n,  // Async reset, active low.
  riscv_dm_bank_if.mem  bank
);

  localparam int LANES = $bits(riscv_dm_pkg::dm_byte_en_t);
  localparam int ROWS  = `RISCV_DM_DEPTH_BYTES / LANES;

  logic [7:0]              mem_q [ROWS][LANES];  // Row by byte lane.
  riscv_dm_pkg::dm_data_t  rdata_q;

  always_ff @(posedge i_riscv_dm_rst or negedge i_riscv_dm_clk_n)
  begin
    if (!i_riscv_dm_clk_n)
    begin
      for (int r = 0; r < ROWS; r++)
      begin
        for (int l = 0; l < LANES; l++)
        begin
          mem_q[r][l] <= 8'h00;
        end
      end
      rdata_q <= '0;
    end
    else if (bank.en)
    begin
      if (bank.we)
      begin
        for (int l = 0; l < LANES; l++)
        begin
          if (bank.byte_en[l])
            mem_q[bank.row][l] <= bank.wdata[8*l +: 8];  // Masked lane write.
        end
      end
      else
      begin
        for (int l = 0; l < LANES; l++)
        begin
          rdata_q[8*l +: 8] <= mem_q[bank.row][l];
        end
      end
    end
  end

  assign bank.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== src/riscv_dm_load_ext.sv ====
`default_nettype none

module riscv_dm_load_ext (
  input  wire logic                      i_riscv_dm_rst,    // Clock.
  input  wire logic                      i_riscv_dm_clk_n,  // Async reset, active low.
  riscv_dm_req_if.ext                    req,
  input  wire riscv_dm_pkg::dm_data_t    i_bank_rdata,
  output riscv_dm_pkg::dm_data_t         o_load_data
);

  localparam int XLEN  = $bits(riscv_dm_pkg::dm_data_t);
  localparam int OFF_W = $bits(riscv_dm_pkg::dm_offset_t);

  riscv_dm_pkg::dm_offset_t  off_q;
  riscv_dm_pkg::dm_size_e    size_q;
  logic                      unsigned_q;
  riscv_dm_pkg::dm_data_t    shifted;     // Addressed byte moved to lane 0.

  // Captured with the bank read, used when the row comes back.
  always_ff @(posedge i_riscv_dm_rst or negedge i_riscv_dm_clk_n)
  begin
    if (!i_riscv_dm_clk_n)
    begin
      off_q      <= '0;
      size_q     <= riscv_dm_pkg::SZ_BYTE;
      unsigned_q <= 1'b0;
    end
    else if (req.en && !req.we)
    begin
      off_q      <= req.addr[OFF_W-1:0];
      size_q     <= req.size;
      unsigned_q <= req.is_unsigned;
    end
  end

  always_comb
  begin
    shifted = i_bank_rdata >> {off_q, 3'b000};
    case (size_q)
      riscv_dm_pkg::SZ_BYTE:
        o_load_data = {{(XLEN-8){!unsigned_q && shifted[7]}}, shifted[7:0]};
      riscv_dm_pkg::SZ_HALF:
        o_load_data = {{(XLEN-16){!unsigned_q && shifted[15]}}, shifted[15:0]};
      riscv_dm_pkg::SZ_WORD:
        o_load_data = {{(XLEN-32){!unsigned_q && shifted[31]}}, shifted[31:0]};
      default:
        o_load_data = shifted;  // Full width, nothing to extend.
    endcase
  end

endmodule

`default_nettype wire

// ==== src/riscv_dm_top.sv ====
`default_nettype none

`include "riscv_dm_settings.svh"

module riscv_dm_top (
  input  wire logic                        i_riscv_dm_rst,    // Clock.
  input  wire logic                        i_riscv_dm_clk_n,  // Async reset, active low.
  input  wire logic                        i_core_req,
  input  wire logic                        i_core_we,
  input  wire riscv_dm_pkg::dm_size_e      i_core_size,
  input  wire logic                        i_core_unsigned,
  input  wire riscv_dm_pkg::dm_addr_t      i_core_addr,
  input  wire riscv_dm_pkg::dm_data_t      i_core_wdata,
  output riscv_dm_pkg::dm_data_t           o_core_rdata,
  output logic                             o_core_rvalid,
  output logic                             o_core_fault,
  input  wire logic                        i_apb_psel,
  input  wire logic                        i_apb_penable,
  input  wire logic                        i_apb_pwrite,
  input  wire riscv_dm_pkg::dm_addr_t      i_apb_paddr,
  input  wire logic [`RISCV_DM_APB_W-1:0]  i_apb_pwdata,
  output logic                             o_apb_pready,
  output logic [`RISCV_DM_APB_W-1:0]       o_apb_prdata,
  output logic                             o_apb_pslverr
);

  riscv_dm_pkg::dm_data_t  load_data;  // Extended load, back to the controller.

  riscv_dm_req_if   u_req_if ();
  riscv_dm_bank_if  u_bank_if ();

  riscv_dm_ctrl u_ctrl (
    .i_riscv_dm_rst   (i_riscv_dm_rst),
    .i_riscv_dm_clk_n (i_riscv_dm_clk_n),
    .i_core_req       (i_core_req),
    .i_core_we        (i_core_we),
    .i_core_size      (i_core_size),
    .i_core_unsigned  (i_core_unsigned),
    .i_core_addr      (i_core_addr),
    .i_core_wdata     (i_core_wdata),
    .o_core_rvalid    (o_core_rvalid),
    .o_core_fault     (o_core_fault),
    .o_core_rdata     (o_core_rdata),
    .i_apb_psel       (i_apb_psel),
    .i_apb_penable    (i_apb_penable),
    .i_apb_pwrite     (i_apb_pwrite),
    .i_apb_paddr      (i_apb_paddr),
    .i_apb_pwdata     (i_apb_pwdata),
    .o_apb_pready     (o_apb_pready),
    .o_apb_prdata     (o_apb_prdata),
    .o_apb_pslverr    (o_apb_pslverr),
    .i_load_data      (load_data),
    .req              (u_req_if.ctrl)
  );

  riscv_dm_store_align u_store_align (
    .req  (u_req_if.dp),
    .bank (u_bank_if.drv)
  );

  riscv_dm_bank u_bank (
    .i_riscv_dm_rst   (i_riscv_dm_rst),
    .i_riscv_dm_clk_n (i_riscv_dm_clk_n),
    .bank             (u_bank_if.mem)
  );

  riscv_dm_load_ext u_load_ext (
    .i_riscv_dm_rst   (i_riscv_dm_rst),
    .i_riscv_dm_clk_n (i_riscv_dm_clk_n),
    .req              (u_req_if.ext),
    .i_bank_rdata     (u_bank_if.rdata),
    .o_load_data      (load_data)
  );

endmodule

`default_nettype wire

// ==== sim/riscv_dm_checker.sv ====
`default_nettype none

`include "riscv_dm_settings.svh"

module riscv_dm_checker (
  input  wire logic                        i_riscv_dm_rst,    // Clock.
  input  wire logic                        i_riscv_dm_clk_n,  // Async reset, active low.
  input  wire logic                        i_core_req,
  input  wire logic                        i_core_we,
  input  wire riscv_dm_pkg::dm_size_e      i_core_size,
  input  wire logic                        i_core_unsigned,
  input  wire riscv_dm_pkg::dm_addr_t      i_core_addr,
  input  wire riscv_dm_pkg::dm_data_t      i_core_wdata,
  input  wire riscv_dm_pkg::dm_data_t      i_core_rdata,
  input  wire logic                        i_core_rvalid,
  input  wire logic                        i_core_fault,
  input  wire logic                        i_apb_psel,
  input  wire logic                        i_apb_penable,
  input  wire logic                        i_apb_pwrite,
  input  wire riscv_dm_pkg::dm_addr_t      i_apb_paddr,
  input  wire logic [`RISCV_DM_APB_W-1:0]  i_apb_pwdata,
  input  wire logic                        i_apb_pready,
  input  wire logic [`RISCV_DM_APB_W-1:0]  i_apb_prdata,
  input  wire logic                        i_apb_pslverr,
  output int                               o_checks,
  output int                               o_errors
);

  localparam int DEPTH = `RISCV_DM_DEPTH_BYTES;
  localparam int XLEN  = $bits(riscv_dm_pkg::dm_data_t);

  logic [7:0]              shadow [DEPTH];  // Expected memory contents.
  logic                    pend_q;          // Core response due this cycle.
  logic                    pend_fault_q;
  riscv_dm_pkg::dm_data_t  pend_data_q;
  riscv_dm_pkg::dm_data_t  exp_word;

  function automatic int size_bytes(input riscv_dm_pkg::dm_size_e sz);
    return 1 << int'(sz);
  endfunction

  function automatic logic misaligned(input riscv_dm_pkg::dm_addr_t addr,
                                      input riscv_dm_pkg::dm_size_e sz);
    return (addr % size_bytes(sz)) != 0;
  endfunction

  function automatic logic apb_bad(input riscv_dm_pkg::dm_addr_t addr);
    return (addr >= DEPTH) || (addr[1:0] != 2'b00);
  endfunction

  // Little-endian gather from the shadow, then sign or zero extension.
  function automatic riscv_dm_pkg::dm_data_t ref_load(input riscv_dm_pkg::dm_addr_t addr,
                                                      input riscv_dm_pkg::dm_size_e sz,
                                                      input logic uns);
    riscv_dm_pkg::dm_data_t v;
    int                     n;
    n = size_bytes(sz);
    v = '0;
    for (int k = 0; k < n; k++)
      v[8*k +: 8] = shadow[int'(addr % DEPTH) + k];
    for (int b = 8*n; b < XLEN; b++)
      v[b] = !uns && v[8*n-1];
    return v;
  endfunction

  task automatic store_bytes(input riscv_dm_pkg::dm_addr_t addr, input int n,
                             input riscv_dm_pkg::dm_data_t data);
    for (int k = 0; k < n; k++)
      shadow[int'(addr % DEPTH) + k] = data[8*k +: 8];
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    o_checks++;
    if (act !== exp)
    begin
      o_errors++;
      $display("mismatch %s expected 0x%h got 0x%h", name, exp, act);
    end
  endtask

  initial
  begin
    o_checks = 0;
    o_errors = 0;
    pend_q   = 1'b0;
  end

  always @(posedge i_riscv_dm_rst or negedge i_riscv_dm_clk_n)
  begin
    if (!i_riscv_dm_clk_n)
    begin
      for (int a = 0; a < DEPTH; a++)
        shadow[a] = 8'h00;  // Memory clears on reset.
      pend_q = 1'b0;
    end
    else
    begin
      if (pend_q)
      begin
        check_value("o_core_rvalid", 64'd1, i_core_rvalid);
        check_value("o_core_fault", pend_fault_q, i_core_fault);
        check_value("o_core_rdata", pend_data_q, i_core_rdata);
      end
      else if (i_core_rvalid || i_core_fault)
      begin
        o_errors++;
        $display("o_core_rvalid or o_core_fault rose without a load or fault behind it");
      end
      if (i_apb_pslverr && !i_apb_pready)
      begin
        o_errors++;
        $display("PSLVERR was high without PREADY");
      end
      if (i_apb_pready && !(i_apb_psel && i_apb_penable))
      begin
        o_errors++;
        $display("PREADY was high outside an APB access phase");
      end
      else if (i_apb_pready)
      begin
        check_value("o_apb_pslverr", apb_bad(i_apb_paddr), i_apb_pslverr);
        if (!apb_bad(i_apb_paddr) && i_apb_pwrite)
          store_bytes(i_apb_paddr, 4, riscv_dm_pkg::dm_data_t'(i_apb_pwdata));
        else if (!apb_bad(i_apb_paddr))
        begin
          exp_word = ref_load(i_apb_paddr, riscv_dm_pkg::SZ_WORD, 1'b1);
          check_value("o_apb_prdata", exp_word[31:0], i_apb_prdata);
        end
      end
      pend_q = 1'b0;
      if (i_core_req && misaligned(i_core_addr, i_core_size))
      begin
        pend_q       = 1'b1;  // Fault answer, memory untouched.
        pend_fault_q = 1'b1;
        pend_data_q  = '0;
      end
      else if (i_core_req && i_core_we)
        store_bytes(i_core_addr, size_bytes(i_core_size), i_core_wdata);
      else if (i_core_req)
      begin
        pend_q       = 1'b1;
        pend_fault_q = 1'b0;
        pend_data_q  = ref_load(i_core_addr, i_core_size, i_core_unsigned);
      end
    end
  end

endmodule

`default_nettype wire

// ==== sim/riscv_dm_tb.sv ====
`default_nettype none

`include "riscv_dm_settings.svh"

module riscv_dm_tb;

  localparam int DEPTH = `RISCV_DM_DEPTH_BYTES;
  localparam int LIMIT = 16;  // Cycles allowed for any single wait.

  logic                        i_riscv_dm_rst;    // Clock.
  logic                        i_riscv_dm_clk_n;  // Reset, active low.
  logic                        i_core_req;
  logic                        i_core_we;
  riscv_dm_pkg::dm_size_e      i_core_size;
  logic                        i_core_unsigned;
  riscv_dm_pkg::dm_addr_t      i_core_addr;
  riscv_dm_pkg::dm_data_t      i_core_wdata;
  riscv_dm_pkg::dm_data_t      o_core_rdata;
  logic                        o_core_rvalid;
  logic                        o_core_fault;
  logic                        i_apb_psel;
  logic                        i_apb_penable;
  logic                        i_apb_pwrite;
  riscv_dm_pkg::dm_addr_t      i_apb_paddr;
  logic [`RISCV_DM_APB_W-1:0]  i_apb_pwdata;
  logic [`RISCV_DM_APB_W-1:0]  o_apb_prdata;
  logic                        o_apb_pready;
  logic                        o_apb_pslverr;
  logic [15:0]                 lfsr_q;
  int                          tb_errors;
  int                          chk_checks;
  int                          chk_errors;

  riscv_dm_top uut (.*);

  riscv_dm_checker u_checker (
    .i_riscv_dm_rst   (i_riscv_dm_rst),
    .i_riscv_dm_clk_n (i_riscv_dm_clk_n),
    .i_core_req       (i_core_req),
    .i_core_we        (i_core_we),
    .i_core_size      (i_core_size),
    .i_core_unsigned  (i_core_unsigned),
    .i_core_addr      (i_core_addr),
    .i_core_wdata     (i_core_wdata),
    .i_core_rdata     (o_core_rdata),
    .i_core_rvalid    (o_core_rvalid),
    .i_core_fault     (o_core_fault),
    .i_apb_psel       (i_apb_psel),
    .i_apb_penable    (i_apb_penable),
    .i_apb_pwrite     (i_apb_pwrite),
    .i_apb_paddr      (i_apb_paddr),
    .i_apb_pwdata     (i_apb_pwdata),
    .i_apb_pready     (o_apb_pready),
    .i_apb_prdata     (o_apb_prdata),
    .i_apb_pslverr    (o_apb_pslverr),
    .o_checks         (chk_checks),
    .o_errors         (chk_errors)
  );

  initial i_riscv_dm_rst = 1'b0;
  always #10 i_riscv_dm_rst = ~i_riscv_dm_rst;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // Taps 16, 14, 13, 11.
  endfunction

  task automatic rand_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[62:0], lfsr_q[0]};
    end
  endtask

  function automatic riscv_dm_pkg::dm_addr_t align(input riscv_dm_pkg::dm_addr_t a,
                                                   input riscv_dm_pkg::dm_size_e sz);
    return a & ~((64'd1 << sz) - 64'd1);
  endfunction

  task automatic core_drive(input logic we, input riscv_dm_pkg::dm_size_e sz, input logic uns,
                            input riscv_dm_pkg::dm_addr_t addr, input riscv_dm_pkg::dm_data_t wdata);
    @(negedge i_riscv_dm_rst);
    i_core_req      = 1'b1;
    i_core_we       = we;
    i_core_size     = sz;
    i_core_unsigned = uns;
    i_core_addr     = addr;
    i_core_wdata    = wdata;
  endtask

  // One request, then wait for rvalid when an answer is due.
  task automatic core_access(input logic we, input riscv_dm_pkg::dm_size_e sz, input logic uns,
                             input riscv_dm_pkg::dm_addr_t addr, input riscv_dm_pkg::dm_data_t wdata,
                             input logic resp);
    int n;
    core_drive(we, sz, uns, addr, wdata);
    @(negedge i_riscv_dm_rst);
    i_core_req = 1'b0;
    n = 0;
    while (resp && !o_core_rvalid && n < LIMIT)
    begin
      @(negedge i_riscv_dm_rst);
      n++;
    end
    if (resp && !o_core_rvalid)
    begin
      tb_errors++;
      $display("timeout waiting for o_core_rvalid at address 0x%h", addr);
    end
  endtask

  task automatic core_burst(input int count);
    logic [63:0]             v;
    riscv_dm_pkg::dm_size_e  sz;
    for (int i = 0; i < count; i++)
    begin
      rand_bits(11, v);
      sz = riscv_dm_pkg::dm_size_e'(v[1:0]);
      core_drive(1'b0, sz, v[2], align(v[10:3], sz), '0);  // Back to back loads.
    end
    @(negedge i_riscv_dm_rst);
    i_core_req = 1'b0;
  endtask

  // Setup, access, then count access cycles until PREADY.
  task automatic apb_transfer(input logic write, input riscv_dm_pkg::dm_addr_t addr,
                              input logic [`RISCV_DM_APB_W-1:0] wdata,
                              output logic [`RISCV_DM_APB_W-1:0] rdata, output logic err,
                              output int cycles);
    int   n;
    logic done;
    @(negedge i_riscv_dm_rst);
    i_apb_psel    = 1'b1;
    i_apb_penable = 1'b0;
    i_apb_pwrite  = write;
    i_apb_paddr   = addr;
    i_apb_pwdata  = wdata;
    @(negedge i_riscv_dm_rst);
    i_apb_penable = 1'b1;
    n    = 0;
    done = 1'b0;
    rdata = '0;
    err   = 1'b1;
    while (!done && n < LIMIT)
    begin
      @(posedge i_riscv_dm_rst);
      n++;
      if (o_apb_pready)
      begin
        done  = 1'b1;
        rdata = o_apb_prdata;
        err   = o_apb_pslverr;
      end
    end
    cycles = n;
    if (!done)
    begin
      tb_errors++;
      $display("timeout waiting for PREADY at address 0x%h", addr);
    end
    @(negedge i_riscv_dm_rst);
    i_apb_psel    = 1'b0;
    i_apb_penable = 1'b0;
  endtask

  task automatic report_test(input string name);
    @(negedge i_riscv_dm_rst);  // Lets the last response be compared.
    $display("test %s done, %0d checks, %0d errors", name, chk_checks, chk_errors + tb_errors);
  endtask

  initial
  begin
    riscv_dm_pkg::dm_size_e      sz;
    riscv_dm_pkg::dm_addr_t      a;
    logic [63:0]                 r;
    logic [63:0]                 s;
    logic [`RISCV_DM_APB_W-1:0]  rd;
    logic                        err;
    int                          cyc;
    lfsr_q           = 16'd8112;
    tb_errors        = 0;
    i_riscv_dm_clk_n = 1'b0;
    i_core_req       = 1'b0;
    i_core_we        = 1'b0;
    i_core_size      = riscv_dm_pkg::SZ_BYTE;
    i_core_unsigned  = 1'b0;
    i_core_addr      = '0;
    i_core_wdata     = '0;
    i_apb_psel       = 1'b0;
    i_apb_penable    = 1'b0;
    i_apb_pwrite     = 1'b0;
    i_apb_paddr      = '0;
    i_apb_pwdata     = '0;
    repeat (10) @(negedge i_riscv_dm_rst);
    i_riscv_dm_clk_n = 1'b1;

    repeat (3)
    begin
      @(negedge i_riscv_dm_rst);
      if (o_core_rvalid || o_apb_pready)
      begin
        tb_errors++;
        $display("o_core_rvalid or PREADY high before any access");
      end
    end
    for (int w = 0; w < DEPTH; w += 4)
      apb_transfer(1'b0, w, '0, rd, err, cyc);
    report_test("1 reset contents");

    for (int i = 0; i < 48; i++)
    begin
      rand_bits(10, r);
      sz = riscv_dm_pkg::dm_size_e'(r[1:0]);
      a  = align(r[9:2], sz);
      rand_bits(64, s);
      core_access(1'b1, sz, 1'b0, a, s, 1'b0);
      rand_bits(6, r);  // Load size, signedness and offset in the same row.
      sz = riscv_dm_pkg::dm_size_e'(r[1:0]);
      core_access(1'b0, sz, r[2], align({a[63:3], r[5:3]}, sz), '0, 1'b1);
    end
    report_test("2 core store and load");

    for (int i = 0; i < 12; i++)
    begin
      rand_bits(11, r);
      sz = (r[1:0] == 2'd0) ? riscv_dm_pkg::SZ_HALF : riscv_dm_pkg::dm_size_e'(r[1:0]);
      a  = r[10:3] | 64'd1;
      rand_bits(64, s);
      core_access(r[2], sz, 1'b0, a, s, 1'b1);
      core_access(1'b0, riscv_dm_pkg::SZ_DWORD, 1'b0, align(a, riscv_dm_pkg::SZ_DWORD), '0, 1'b1);
    end
    report_test("3 misaligned fault");

    for (int i = 0; i < 16; i++)
    begin
      rand_bits(40, r);
      a = align(r[39:32], riscv_dm_pkg::SZ_WORD);
      apb_transfer(1'b1, a, r[31:0], rd, err, cyc);
      core_access(1'b0, riscv_dm_pkg::SZ_DWORD, 1'b0, align(a, riscv_dm_pkg::SZ_DWORD), '0, 1'b1);
      rand_bits(10, r);
      sz = riscv_dm_pkg::dm_size_e'(r[1:0]);
      a  = align(r[9:2], sz);
      rand_bits(64, s);
      core_access(1'b1, sz, 1'b0, a, s, 1'b0);
      apb_transfer(1'b0, align(a, riscv_dm_pkg::SZ_WORD), '0, rd, err, cyc);
    end
    report_test("4 core and APB agree");

    for (int i = 0; i < 8; i++)
    begin
      rand_bits(42, r);
      a = (i % 2 == 0) ? 64'(DEPTH) + r[41:32] : (r[39:32] | 64'd1);
      apb_transfer(1'b1, a, r[31:0], rd, err, cyc);
      apb_transfer(1'b0, a, '0, rd, err, cyc);
      apb_transfer(1'b0, align(a % DEPTH, riscv_dm_pkg::SZ_WORD), '0, rd, err, cyc);
    end
    report_test("5 APB slave error");

    for (int i = 0; i < 4; i++)
    begin
      rand_bits(40, r);
      a = align(r[39:32], riscv_dm_pkg::SZ_WORD);
      fork
        apb_transfer(i[0], a, r[31:0], rd, err, cyc);
        begin
          @(negedge i_riscv_dm_rst);
          core_burst(3);
        end
      join
      if (cyc != (i[0] ? 4 : 5))
      begin
        tb_errors++;
        $display("mismatch PREADY latency expected 0x%h got 0x%h", (i[0] ? 4 : 5), cyc);
      end
    end
    report_test("6 core back-pressure on APB");

    repeat (2) @(negedge i_riscv_dm_rst);
    $display("summary: %0d checks, %0d errors", chk_checks, chk_errors + tb_errors);
    if (chk_errors + tb_errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== riscv_dm_mem.f ====
+incdir+include
src/riscv_dm_pkg.sv
src/riscv_dm_if.sv
src/riscv_dm_ctrl.sv
src/riscv_dm_store_align.sv
src/riscv_dm_bank.sv
src/riscv_dm_load_ext.sv
src/riscv_dm_top.sv
sim/riscv_dm_checker.sv
sim/riscv_dm_tb.sv
